/* src.f */
dcache_pkg.sv
dcache_way_if.sv
dcache_way.sv
dcache_ctrl.sv
dcache_top.sv
tb_clock.sv
dcache_mem_model.sv
dcache_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module dcache_tb -f src.f -Mdir obj_dir -o dcache_sim
./obj_dir/dcache_sim | tee sim.log

if grep -q "TESTS PASSED" sim.log; then
    exit 0
fi
exit 1

/* dcache_tb.sv */
`default_nettype none

module dcache_tb;

    localparam int index_width = dcache_pkg::default_index_width;
    localparam int offset_width = dcache_pkg::default_offset_width;
    localparam int line_bytes = 4 * (2 ** offset_width);
    localparam int wait_limit = 200;

    logic                            clk;
    logic                            rst;
    logic                            req_valid;
    logic                            req_write;
    dcache_pkg::addr_t               req_addr;
    dcache_pkg::word_t               req_wdata;
    dcache_pkg::strb_t               req_wstrb;
    logic                            req_ready;
    logic                            resp_valid;
    dcache_pkg::word_t               resp_rdata;
    logic                            mem_req;
    logic                            mem_write;
    dcache_pkg::addr_t               mem_addr;
    dcache_pkg::word_t               mem_wdata;
    dcache_pkg::strb_t               mem_wstrb;
    logic                            mem_addr_ok;
    logic                            mem_data_ok;
    logic [32*(2**offset_width)-1:0] mem_rline;

    integer            seed;
    int                errors = 0;
    int                cycle = 0;
    int                resp_count = 0;
    int                accept_cycle = 0;
    int                resp_cycle = 0;
    logic              pop_read;
    dcache_pkg::word_t pop_word;

    // expected responses in request order
    logic              exp_read [$];
    dcache_pkg::word_t exp_word [$];
    // memory transactions of the current request
    dcache_pkg::addr_t rd_addr_q [$];
    dcache_pkg::addr_t wr_addr_q [$];
    dcache_pkg::word_t wr_data_q [$];
    dcache_pkg::strb_t wr_strb_q [$];
    dcache_pkg::word_t ref_mem [dcache_pkg::addr_t];

    tb_clock clock_inst (.clk(clk));

    dcache_top #(
        .index_width(index_width),
        .offset_width(offset_width)
    ) dcache_top_inst (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_write(req_write), .req_addr(req_addr),
        .req_wdata(req_wdata), .req_wstrb(req_wstrb), .req_ready(req_ready),
        .resp_valid(resp_valid), .resp_rdata(resp_rdata),
        .mem_req(mem_req), .mem_write(mem_write), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb), .mem_addr_ok(mem_addr_ok),
        .mem_data_ok(mem_data_ok), .mem_rline(mem_rline)
    );

    dcache_mem_model #(.offset_width(offset_width)) mem_inst (
        .clk(clk), .rst(rst),
        .mem_req(mem_req), .mem_write(mem_write), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb), .mem_addr_ok(mem_addr_ok),
        .mem_data_ok(mem_data_ok), .mem_rline(mem_rline)
    );

    ////////////////////////////////////////////////////////////////////////////
    // reference and compare
    ////////////////////////////////////////////////////////////////////////////

    // word seen by this request, after any write it makes
    function automatic dcache_pkg::word_t expected_word(input logic write,
        input dcache_pkg::addr_t addr, input dcache_pkg::word_t wdata,
        input dcache_pkg::strb_t strb);
        dcache_pkg::addr_t key;
        dcache_pkg::word_t w;
        key = {addr[31:2], 2'b00};
        // memory's initial contents where nothing was written yet
        w = ref_mem.exists(key) ? ref_mem[key] : ({~key[15:0], key[31:16]} ^ 32'h3c5a_96e1);
        if (write) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    w[b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
            ref_mem[key] = w;
        end
        return w;
    endfunction

    function automatic dcache_pkg::addr_t make_addr(input int tag, input int set, input int word);
        return dcache_pkg::addr_t'((tag << (index_width + offset_width + 2)) |
                                   (set << (offset_width + 2)) | (word << 2));
    endfunction

    task automatic check_word(input string name, input dcache_pkg::word_t got,
                              input dcache_pkg::word_t exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input dcache_pkg::addr_t got,
                              input dcache_pkg::addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_strb(input string name, input dcache_pkg::strb_t got,
                              input dcache_pkg::strb_t exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (!rst && mem_req && mem_addr_ok) begin
            if (mem_write) begin
                wr_addr_q.push_back(mem_addr);
                wr_data_q.push_back(mem_wdata);
                wr_strb_q.push_back(mem_wstrb);
            end else begin
                rd_addr_q.push_back(mem_addr);
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && resp_valid) begin
            if (exp_read.size() == 0) begin
                errors++;
                $display("response arrived with no request outstanding");
            end else begin
                pop_read = exp_read.pop_front();
                pop_word = exp_word.pop_front();
                if (pop_read) begin
                    check_word("resp_rdata", resp_rdata, pop_word);
                end
            end
            resp_count++;
            resp_cycle = cycle;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // request driving
    ////////////////////////////////////////////////////////////////////////////

    task automatic issue(input logic write, input dcache_pkg::addr_t addr,
                         input dcache_pkg::word_t wdata, input dcache_pkg::strb_t strb);
        int   waited;
        logic accepted;
        waited = 0;
        accepted = 1'b0;
        @(negedge clk);
        req_valid = 1'b1;
        req_write = write;
        req_addr = addr;
        req_wdata = wdata;
        req_wstrb = strb;
        exp_read.push_back(!write);
        exp_word.push_back(expected_word(write, addr, wdata, strb));
        while (!accepted && waited < wait_limit) begin
            @(posedge clk);
            accepted = req_ready;
            accept_cycle = cycle;
            waited++;
        end
        @(negedge clk);
        req_valid = 1'b0;
        if (!accepted) begin
            errors++;
            $display("timeout: request to %h was never accepted", addr);
        end
    endtask

    task automatic wait_response(input int target);
        int waited;
        waited = 0;
        while (resp_count < target && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (resp_count < target) begin
            errors++;
            $display("timeout: no response for request number %0d", target);
        end
    endtask

    // reads < 0 leaves the number of line reads open
    task automatic run_op(input logic write, input dcache_pkg::addr_t addr,
                          input dcache_pkg::word_t wdata, input dcache_pkg::strb_t strb,
                          input int reads, input logic hit_timing);
        int                target;
        dcache_pkg::addr_t line_addr;
        target = resp_count + 1;
        line_addr = addr & ~dcache_pkg::addr_t'(line_bytes - 1);
        rd_addr_q.delete();
        wr_addr_q.delete();
        wr_data_q.delete();
        wr_strb_q.delete();
        issue(write, addr, wdata, strb);
        wait_response(target);
        if (hit_timing && (resp_cycle - accept_cycle != 1)) begin
            errors++;
            $display("read hit at %h answered %0d cycles after accept instead of 1",
                     addr, resp_cycle - accept_cycle);
        end
        if (write) begin
            if (wr_addr_q.size() != 1 || rd_addr_q.size() != 0) begin
                errors++;
                $display("write to %h made %0d memory writes and %0d reads, expected 1 and 0",
                         addr, wr_addr_q.size(), rd_addr_q.size());
            end else begin
                check_addr("mem_addr", wr_addr_q[0], {addr[31:2], 2'b00});
                check_word("mem_wdata", wr_data_q[0], wdata);
                check_strb("mem_wstrb", wr_strb_q[0], strb);
            end
        end else begin
            if (wr_addr_q.size() != 0 || rd_addr_q.size() > 1 ||
                (reads >= 0 && rd_addr_q.size() != reads)) begin
                errors++;
                $display("read of %h made %0d memory reads and %0d writes, expected %0d reads",
                         addr, rd_addr_q.size(), wr_addr_q.size(), reads);
            end
            foreach (rd_addr_q[i]) begin
                check_addr("mem_addr", rd_addr_q[i], line_addr);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0]       r;
        dcache_pkg::addr_t a;
        dcache_pkg::strb_t s;
        seed = 32'h799e82e7;
        rst = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr = '0;
        req_wdata = '0;
        req_wstrb = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        if (req_ready !== 1'b1 || resp_valid !== 1'b0 || mem_req !== 1'b0) begin
            errors++;
            $display("outputs are not in their reset state after reset");
        end

        // miss refills the line, next word of it hits
        run_op(1'b0, make_addr(1, 0, 2), '0, '0, 1, 1'b0);
        run_op(1'b0, make_addr(1, 0, 1), '0, '0, 0, 1'b1);
        // partial write hit, then read back from the cache
        run_op(1'b1, make_addr(1, 0, 1), 32'hdead_beef, 4'b0101, 0, 1'b0);
        run_op(1'b0, make_addr(1, 0, 1), '0, '0, 0, 1'b1);
        // write miss does not allocate
        run_op(1'b1, make_addr(2, 1, 3), 32'h1234_5678, 4'b0110, 0, 1'b0);
        run_op(1'b0, make_addr(2, 1, 3), '0, '0, 1, 1'b0);

        // lines A, B, C share set 5, B is the victim after A is reused
        run_op(1'b0, make_addr(1, 5, 0), '0, '0, 1, 1'b0);
        run_op(1'b0, make_addr(2, 5, 0), '0, '0, 1, 1'b0);
        run_op(1'b0, make_addr(1, 5, 1), '0, '0, 0, 1'b1);
        run_op(1'b0, make_addr(3, 5, 2), '0, '0, 1, 1'b0);
        run_op(1'b0, make_addr(1, 5, 3), '0, '0, 0, 1'b1);
        run_op(1'b0, make_addr(2, 5, 0), '0, '0, 1, 1'b0);

        // random traffic over sets 8 to 10
        for (int n = 0; n < 200; n++) begin
            r = $random(seed);
            a = make_addr(int'(r[1:0]), 8 + int'(r[3:2]) % 3, int'(r[5:4]));
            s = (r[9:6] == 4'b0000) ? 4'b1111 : r[9:6];
            run_op(r[10], a, $random(seed), s, -1, 1'b0);
        end

        $display("closing: %0d errors, %0d responses, %0d responses missing",
                 errors, resp_count, exp_read.size());
        if (errors == 0 && exp_read.size() == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dcache_mem_model.sv */
`default_nettype none

module dcache_mem_model #(
    parameter int offset_width = dcache_pkg::default_offset_width
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            mem_req,
    input  logic                            mem_write,
    input  dcache_pkg::addr_t               mem_addr,
    input  dcache_pkg::word_t               mem_wdata,
    input  dcache_pkg::strb_t               mem_wstrb,
    output logic                            mem_addr_ok,
    output logic                            mem_data_ok,
    output logic [32*(2**offset_width)-1:0] mem_rline
);

    localparam int words = 2 ** offset_width;

    integer            seed;
    int                delay;
    logic              write_q;
    dcache_pkg::addr_t addr_q;
    dcache_pkg::word_t wdata_q;
    dcache_pkg::strb_t strb_q;

    // shadow of the memory, keyed by word address
    dcache_pkg::word_t shadow [dcache_pkg::addr_t];

    function automatic dcache_pkg::word_t read_word(input dcache_pkg::addr_t addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        // untouched words hold a pattern of their own address
        return {~addr[15:0], addr[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    task automatic store(input dcache_pkg::addr_t addr, input dcache_pkg::word_t data,
                         input dcache_pkg::strb_t strb);
        dcache_pkg::word_t w;
        w = read_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                w[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        shadow[addr] = w;
    endtask

    // one transaction at a time, 0 to 5 cycles before each handshake
    initial begin
        seed = 32'h799e82e7;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rline = '0;
        forever begin
            @(negedge clk);
            if (!rst && mem_req) begin
                delay = $unsigned($random(seed)) % 6;
                repeat (delay) @(negedge clk);
                write_q = mem_write;
                addr_q = mem_addr;
                wdata_q = mem_wdata;
                strb_q = mem_wstrb;
                mem_addr_ok = 1'b1;
                @(negedge clk);
                mem_addr_ok = 1'b0;
                delay = $unsigned($random(seed)) % 6;
                repeat (delay) @(negedge clk);
                if (write_q) begin
                    store(addr_q, wdata_q, strb_q);
                end else begin
                    for (int i = 0; i < words; i++) begin
                        mem_rline[i*32 +: 32] = read_word(addr_q + 4 * i);
                    end
                end
                mem_data_ok = 1'b1;
                @(negedge clk);
                mem_data_ok = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* tb_clock.sv */
`default_nettype none

module tb_clock #(
    parameter int half_period = 5
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

endmodule

`default_nettype wire

/* dcache_top.sv */
`default_nettype none

module dcache_top #(
    parameter int index_width = dcache_pkg::default_index_width,
    parameter int offset_width = dcache_pkg::default_offset_width
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            req_valid,
    input  logic                            req_write,
    input  dcache_pkg::addr_t               req_addr,
    input  dcache_pkg::word_t               req_wdata,
    input  dcache_pkg::strb_t               req_wstrb,
    output logic                            req_ready,
    output logic                            resp_valid,
    output dcache_pkg::word_t               resp_rdata,
    output logic                            mem_req,
    output logic                            mem_write,
    output dcache_pkg::addr_t               mem_addr,
    output dcache_pkg::word_t               mem_wdata,
    output dcache_pkg::strb_t               mem_wstrb,
    input  logic                            mem_addr_ok,
    input  logic                            mem_data_ok,
    input  logic [32*(2**offset_width)-1:0] mem_rline
);

    dcache_way_if #(
        .index_width(index_width),
        .offset_width(offset_width)
    ) way0_bus ();

    dcache_way_if #(
        .index_width(index_width),
        .offset_width(offset_width)
    ) way1_bus ();

    dcache_way #(
        .index_width(index_width),
        .offset_width(offset_width)
    ) way0_inst (
        .clk(clk),
        .rst(rst),
        .bus(way0_bus.way)
    );

    dcache_way #(
        .index_width(index_width),
        .offset_width(offset_width)
    ) way1_inst (
        .clk(clk),
        .rst(rst),
        .bus(way1_bus.way)
    );

    dcache_ctrl #(
        .index_width(index_width),
        .offset_width(offset_width)
    ) ctrl_inst (
        .clk(clk),
        .rst(rst),
        .req_valid(req_valid),
        .req_write(req_write),
        .req_addr(req_addr),
        .req_wdata(req_wdata),
        .req_wstrb(req_wstrb),
        .req_ready(req_ready),
        .resp_valid(resp_valid),
        .resp_rdata(resp_rdata),
        .mem_req(mem_req),
        .mem_write(mem_write),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_wstrb(mem_wstrb),
        .mem_addr_ok(mem_addr_ok),
        .mem_data_ok(mem_data_ok),
        .mem_rline(mem_rline),
        .way0(way0_bus.ctrl),
        .way1(way1_bus.ctrl)
    );

endmodule

`default_nettype wire

/* dcache_ctrl.sv */
`default_nettype none

module dcache_ctrl #(
    parameter int index_width = dcache_pkg::default_index_width,
    parameter int offset_width = dcache_pkg::default_offset_width
) (
    input  logic                            clk,
    input  logic                            rst,
    // pipeline side
    input  logic                            req_valid,
    input  logic                            req_write,
    input  dcache_pkg::addr_t               req_addr,
    input  dcache_pkg::word_t               req_wdata,
    input  dcache_pkg::strb_t               req_wstrb,
    output logic                            req_ready,
    output logic                            resp_valid,
    output dcache_pkg::word_t               resp_rdata,
    // memory side
    output logic                            mem_req,
    output logic                            mem_write,
    output dcache_pkg::addr_t               mem_addr,
    output dcache_pkg::word_t               mem_wdata,
    output dcache_pkg::strb_t               mem_wstrb,
    input  logic                            mem_addr_ok,
    input  logic                            mem_data_ok,
    input  logic [32*(2**offset_width)-1:0] mem_rline,
    // ways
    dcache_way_if.ctrl                      way0,
    dcache_way_if.ctrl                      way1
);

    localparam int tag_width = 30 - index_width - offset_width;
    localparam int line_width = 32 * (2 ** offset_width);
    localparam int sets = 2 ** index_width;
    localparam int index_lsb = offset_width + 2;
    localparam int tag_lsb = index_width + offset_width + 2;

    dcache_pkg::ctrl_state_t state;
    dcache_pkg::ctrl_state_t state_next;

    // request buffer
    dcache_pkg::addr_t       buf_addr;
    dcache_pkg::word_t       buf_wdata;
    dcache_pkg::strb_t       buf_wstrb;
    logic                    buf_write;
    logic [offset_width-1:0] buf_offset;
    logic [index_width-1:0]  buf_index;
    logic [tag_width-1:0]    buf_tag;

    logic                    accept;
    logic                    hit_any;
    logic                    hit_way;
    logic [line_width-1:0]   hit_line;
    dcache_pkg::word_t       hit_word;
    logic [sets-1:0]         lru;
    logic                    victim;
    logic                    fill_done;
    logic                    resp_pend;
    dcache_pkg::word_t       resp_word;

    function automatic dcache_pkg::word_t select_word(
        input logic [line_width-1:0]   line,
        input logic [offset_width-1:0] sel
    );
        return line[sel*32 +: 32];
    endfunction

    assign accept = req_valid && req_ready;
    assign buf_offset = buf_addr[index_lsb-1:2];
    assign buf_index = buf_addr[tag_lsb-1:index_lsb];
    assign buf_tag = buf_addr[31:tag_lsb];

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_addr <= req_addr;
            buf_wdata <= req_wdata;
            buf_wstrb <= req_wstrb;
            buf_write <= req_write;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // main FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= dcache_pkg::idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            dcache_pkg::idle: begin
                if (accept) state_next = dcache_pkg::lookup;
            end
            dcache_pkg::lookup: begin
                // writes go through to memory whether they hit or not
                if (buf_write) state_next = dcache_pkg::write_addr;
                else if (!hit_any) state_next = dcache_pkg::miss_addr;
                else state_next = dcache_pkg::idle;
            end
            dcache_pkg::miss_addr: begin
                if (mem_addr_ok) state_next = dcache_pkg::miss_data;
            end
            dcache_pkg::miss_data: begin
                if (mem_data_ok) state_next = dcache_pkg::idle;
            end
            dcache_pkg::write_addr: begin
                if (mem_addr_ok) state_next = dcache_pkg::write_data;
            end
            dcache_pkg::write_data: begin
                if (mem_data_ok) state_next = dcache_pkg::idle;
            end
            default: state_next = dcache_pkg::idle;
        endcase
    end

    assign req_ready = (state == dcache_pkg::idle);
    assign fill_done = (state == dcache_pkg::miss_data) && mem_data_ok;

    ////////////////////////////////////////////////////////////////////////////
    // hit combine, LRU and response
    ////////////////////////////////////////////////////////////////////////////

    assign hit_any = way0.hit || way1.hit;
    assign hit_way = way1.hit;
    assign hit_line = hit_way ? way1.rd_line : way0.rd_line;
    assign hit_word = select_word(hit_line, buf_offset);

    // lru bit holds the way to replace next
    assign victim = lru[buf_index];

    always_ff @(posedge clk) begin
        if (rst) begin
            lru <= '0;
        end else if ((state == dcache_pkg::lookup) && hit_any) begin
            lru[buf_index] <= ~hit_way;
        end else if (fill_done) begin
            lru[buf_index] <= ~victim;
        end
    end

    // misses and writes answer on the cycle after data_ok
    always_ff @(posedge clk) begin
        if (rst) begin
            resp_pend <= 1'b0;
        end else begin
            resp_pend <= mem_data_ok && ((state == dcache_pkg::miss_data) ||
                                         (state == dcache_pkg::write_data));
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done) begin
            resp_word <= select_word(mem_rline, buf_offset);
        end
    end

    assign resp_valid = resp_pend ||
                        ((state == dcache_pkg::lookup) && !buf_write && hit_any);
    assign resp_rdata = resp_pend ? resp_word : hit_word;

    ////////////////////////////////////////////////////////////////////////////
    // way control
    ////////////////////////////////////////////////////////////////////////////

    assign way0.rd_en = accept;
    assign way0.rd_index = req_addr[tag_lsb-1:index_lsb];
    assign way0.cmp_tag = buf_tag;
    assign way0.fill = fill_done && !victim;
    assign way0.wr_en = (state == dcache_pkg::lookup) && buf_write && way0.hit;
    assign way0.wr_index = buf_index;
    assign way0.wr_tag = buf_tag;
    assign way0.wr_word_sel = buf_offset;
    assign way0.wr_strb = buf_wstrb;
    assign way0.wr_word = buf_wdata;
    assign way0.wr_line = mem_rline;

    assign way1.rd_en = accept;
    assign way1.rd_index = req_addr[tag_lsb-1:index_lsb];
    assign way1.cmp_tag = buf_tag;
    assign way1.fill = fill_done && victim;
    assign way1.wr_en = (state == dcache_pkg::lookup) && buf_write && way1.hit;
    assign way1.wr_index = buf_index;
    assign way1.wr_tag = buf_tag;
    assign way1.wr_word_sel = buf_offset;
    assign way1.wr_strb = buf_wstrb;
    assign way1.wr_word = buf_wdata;
    assign way1.wr_line = mem_rline;

    // memory port, reads fetch the aligned line
    assign mem_req = (state == dcache_pkg::miss_addr) || (state == dcache_pkg::write_addr);
    assign mem_write = buf_write;
    assign mem_addr = buf_write ? {buf_addr[31:2], 2'b00} :
                                  {buf_addr[31:index_lsb], {index_lsb{1'b0}}};
    assign mem_wdata = buf_wdata;
    assign mem_wstrb = buf_write ? buf_wstrb : 4'b0000;

endmodule

`default_nettype wire

/* dcache_way.sv */
`default_nettype none

module dcache_way #(
    parameter int index_width = dcache_pkg::default_index_width,
    parameter int offset_width = dcache_pkg::default_offset_width
) (
    input  logic      clk,
    input  logic      rst,
    dcache_way_if.way bus
);

    localparam int tag_width = 30 - index_width - offset_width;
    localparam int line_width = 32 * (2 ** offset_width);
    localparam int sets = 2 ** index_width;

    logic [tag_width-1:0]  tag_mem  [sets];
    logic [line_width-1:0] line_mem [sets];
    logic [sets-1:0]       valid;

    // registered read of the addressed set
    logic [tag_width-1:0]  tag_q;
    logic [line_width-1:0] line_q;
    logic                  valid_q;

    ////////////////////////////////////////////////////////////////////////////
    // read port and tag compare
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (bus.rd_en) begin
            tag_q <= tag_mem[bus.rd_index];
            line_q <= line_mem[bus.rd_index];
        end
    end

    // compare against the tag that the controller holds in lookup
    assign bus.hit = valid_q && (tag_q == bus.cmp_tag);
    assign bus.rd_line = line_q;

    ////////////////////////////////////////////////////////////////////////////
    // valid bits
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            valid_q <= 1'b0;
        end else begin
            if (bus.fill) begin
                valid[bus.wr_index] <= 1'b1;
            end
            if (bus.rd_en) begin
                valid_q <= valid[bus.rd_index];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // line refill and byte-merged word write
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (bus.fill) begin
            tag_mem[bus.wr_index] <= bus.wr_tag;
            line_mem[bus.wr_index] <= bus.wr_line;
        end else if (bus.wr_en) begin
            // only the enabled bytes of the selected word change
            for (int b = 0; b < 4; b++) begin
                if (bus.wr_strb[b]) begin
                    line_mem[bus.wr_index][bus.wr_word_sel*32 + b*8 +: 8] <=
                        bus.wr_word[b*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* dcache_way_if.sv */
`default_nettype none

interface dcache_way_if #(
    parameter int index_width = dcache_pkg::default_index_width,
    parameter int offset_width = dcache_pkg::default_offset_width
);

    localparam int tag_width = 30 - index_width - offset_width;
    localparam int line_width = 32 * (2 ** offset_width);

    // lookup, read on the accept edge and compared one cycle later
    logic                    rd_en;
    logic [index_width-1:0]  rd_index;
    logic [tag_width-1:0]    cmp_tag;
    logic                    hit;
    logic [line_width-1:0]   rd_line;

    // refill of a whole line, or a strobed word write
    logic                    fill;
    logic                    wr_en;
    logic [index_width-1:0]  wr_index;
    logic [tag_width-1:0]    wr_tag;
    logic [offset_width-1:0] wr_word_sel;
    dcache_pkg::strb_t       wr_strb;
    dcache_pkg::word_t       wr_word;
    logic [line_width-1:0]   wr_line;

    modport way (
        input  rd_en, rd_index, cmp_tag,
        input  fill, wr_en, wr_index, wr_tag, wr_word_sel, wr_strb, wr_word, wr_line,
        output hit, rd_line
    );

    modport ctrl (
        output rd_en, rd_index, cmp_tag,
        output fill, wr_en, wr_index, wr_tag, wr_word_sel, wr_strb, wr_word, wr_line,
        input  hit, rd_line
    );

endinterface

`default_nettype wire

/* dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // data types
    ////////////////////////////////////////////////////////////////////////////

    // one data word on the pipeline and memory ports
    typedef logic [31:0] word_t;

    // byte address
    typedef logic [31:0] addr_t;

    // byte enables of one word, bit n covers bits 8n+7:8n
    typedef logic [3:0] strb_t;

    ////////////////////////////////////////////////////////////////////////////
    // controller states
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        idle       = 3'd0,
        lookup     = 3'd1,
        miss_addr  = 3'd2,
        miss_data  = 3'd3,
        write_addr = 3'd4,
        write_data = 3'd5
    } ctrl_state_t;

    // default geometry: 16 sets of 4-word lines
    localparam int default_index_width = 4;
    localparam int default_offset_width = 2;

endpackage

`default_nettype wire
